//--- rtl/spi_reg_pkg.sv
package spi_reg_pkg;

    // host register map in the low 16 bus addresses.
    typedef enum logic [3:0] {
        REG_RESET   = 4'd0,  // write strobes a soft reset.
        REG_START   = 4'd1,  // write strobes a software start.
        REG_STATUS  = 4'd2,  // bit 0 is the done flag.
        REG_BITS_LO = 4'd3,
        REG_BITS_HI = 4'd4,
        REG_WAIT_LO = 4'd5,
        REG_WAIT_HI = 4'd6,
        REG_REPEAT  = 4'd7,  // zero repeats forever.
        REG_CONF    = 4'd8   // bit 0 enables the external start.
    } reg_addr_e;

    // first address of the transmit buffer.
    localparam int REG_SPACE = 16;

    localparam int BUS_DW = 8;  // host bus is byte wide.

endpackage

//--- rtl/spi_seq_pkg.sv
package spi_seq_pkg;

    // the sequencer either idles, shifts a burst out or sits in the gap.
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_SHIFT = 2'd1,
        SEQ_WAIT  = 2'd2
    } seq_state_e;

    // bit, wait and repeat counts all share this width.
    localparam int CNT_W = 16;

endpackage

//--- rtl/spi_ifs.sv
`timescale 1ns/1ps

interface spi_cfg_if import spi_seq_pkg::*; ();
    logic [CNT_W-1:0] bit_out;
    logic [CNT_W-1:0] wait_cnt;
    logic [CNT_W-1:0] repeat_cnt;
    logic             ext_en;
    logic             start;     // one cycle per write to the start register.
    logic             soft_rst;
    logic             done;      // one cycle when the last repeat ends.

    modport regs (output bit_out, wait_cnt, repeat_cnt, ext_en, start, soft_rst, input done);
    modport seq  (input bit_out, wait_cnt, repeat_cnt, ext_en, start, soft_rst, output done);
endinterface

interface spi_buf_bus_if import spi_reg_pkg::*; #(parameter int MEM_BYTES = 16) ();
    logic [$clog2(2*MEM_BYTES)-1:0] byte_addr;  // spans transmit then receive buffer.
    logic                           we;
    logic [BUS_DW-1:0]              wdata;
    logic [BUS_DW-1:0]              rdata;

    modport host (output byte_addr, we, wdata, input rdata);
    modport mem  (input byte_addr, we, wdata, output rdata);
endinterface

interface spi_stream_if import spi_seq_pkg::*; ();
    logic [CNT_W-1:0] bit_addr;
    logic             rx_we;
    logic             sen_int;
    logic             tx_bit;   // data for the address of the previous cycle.
    logic             rx_bit;

    modport seq  (output bit_addr, rx_we, sen_int);
    modport mem  (input bit_addr, rx_we, rx_bit, output tx_bit);
    modport line (input sen_int, tx_bit, output rx_bit);
endinterface

//--- rtl/spi_bus_regs.sv
`timescale 1ns/1ps

module spi_bus_regs import spi_reg_pkg::*, spi_seq_pkg::*; #(
    parameter int MEM_BYTES = 16,
    parameter int ADDR_W    = 16
) (
    input  logic              SPI_CLK,
    input  logic              RST_SYNC,
    input  logic [ADDR_W-1:0] bus_add,
    input  logic [BUS_DW-1:0] bus_data_in,
    output logic [BUS_DW-1:0] bus_data_out,
    input  logic              bus_wr,
    input  logic              bus_rd,
    spi_cfg_if.regs           cfg,
    spi_buf_bus_if.host       buf_bus
);

    localparam int BUF_AW = $clog2(2 * MEM_BYTES);
    localparam logic [ADDR_W-1:0] TX_BASE = ADDR_W'(REG_SPACE);
    localparam logic [ADDR_W-1:0] RX_BASE = ADDR_W'(REG_SPACE + MEM_BYTES);
    localparam logic [ADDR_W-1:0] BUF_END = ADDR_W'(REG_SPACE + 2 * MEM_BYTES);

    // the serial side takes bit 0 of a stored byte first, the bus side the MSB.
    function automatic logic [BUS_DW-1:0] bit_rev(input logic [BUS_DW-1:0] d);
        logic [BUS_DW-1:0] r;
        for (int i = 0; i < BUS_DW; i++) begin
            r[i] = d[BUS_DW-1-i];
        end
        return r;
    endfunction

    reg_addr_e         reg_sel;
    logic [ADDR_W-1:0] buf_off;
    logic [ADDR_W-1:0] rd_addr_q;
    logic [CNT_W-1:0]  bit_out_q;
    logic [CNT_W-1:0]  wait_cnt_q;
    logic [BUS_DW-1:0] repeat_q;
    logic [BUS_DW-1:0] reg_rdata;
    logic [BUS_DW-1:0] reg_rdata_q;
    logic              ext_en_q;
    logic              start_q;
    logic              soft_rst_q;
    logic              done_q;
    logic              reg_wr;
    logic              tx_wr;

    assign reg_sel = reg_addr_e'(bus_add[3:0]);
    assign reg_wr  = bus_wr && (bus_add < TX_BASE);
    assign tx_wr   = bus_wr && (bus_add >= TX_BASE) && (bus_add < RX_BASE);

    always_ff @(posedge SPI_CLK) begin
        if (RST_SYNC) begin
            bit_out_q  <= '0;
            wait_cnt_q <= '0;
            repeat_q   <= '0;
            ext_en_q   <= 1'b0;
            start_q    <= 1'b0;
            soft_rst_q <= 1'b0;
        end else begin
            start_q    <= reg_wr && (reg_sel == REG_START);
            soft_rst_q <= reg_wr && (reg_sel == REG_RESET);
            if (reg_wr) begin
                case (reg_sel)
                    REG_BITS_LO: bit_out_q[BUS_DW-1:0]      <= bus_data_in;
                    REG_BITS_HI: bit_out_q[CNT_W-1:BUS_DW]  <= bus_data_in;
                    REG_WAIT_LO: wait_cnt_q[BUS_DW-1:0]     <= bus_data_in;
                    REG_WAIT_HI: wait_cnt_q[CNT_W-1:BUS_DW] <= bus_data_in;
                    REG_REPEAT:  repeat_q                   <= bus_data_in;
                    REG_CONF:    ext_en_q                   <= bus_data_in[0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge SPI_CLK) begin
        if (RST_SYNC || soft_rst_q) begin
            done_q <= 1'b1;  // idle reads as done.
        end else if (start_q) begin
            done_q <= 1'b0;
        end else if (cfg.done) begin
            done_q <= 1'b1;
        end
    end

    always_comb begin
        case (reg_sel)
            REG_STATUS:  reg_rdata = {{(BUS_DW-1){1'b0}}, done_q};
            REG_BITS_LO: reg_rdata = bit_out_q[BUS_DW-1:0];
            REG_BITS_HI: reg_rdata = bit_out_q[CNT_W-1:BUS_DW];
            REG_WAIT_LO: reg_rdata = wait_cnt_q[BUS_DW-1:0];
            REG_WAIT_HI: reg_rdata = wait_cnt_q[CNT_W-1:BUS_DW];
            REG_REPEAT:  reg_rdata = repeat_q;
            REG_CONF:    reg_rdata = {{(BUS_DW-1){1'b0}}, ext_en_q};
            default:     reg_rdata = '0;
        endcase
    end

    always_ff @(posedge SPI_CLK) begin
        if (RST_SYNC) begin
            rd_addr_q   <= '0;
            reg_rdata_q <= '0;
        end else if (bus_rd) begin
            rd_addr_q   <= bus_add;
            reg_rdata_q <= reg_rdata;
        end
    end

    // buffer data arrives one cycle after the address, in step with rd_addr_q.
    always_comb begin
        if (rd_addr_q < TX_BASE) begin
            bus_data_out = reg_rdata_q;
        end else if (rd_addr_q < BUF_END) begin
            bus_data_out = bit_rev(buf_bus.rdata);
        end else begin
            bus_data_out = '0;
        end
    end

    assign buf_off           = bus_add - TX_BASE;
    assign buf_bus.byte_addr = buf_off[BUF_AW-1:0];
    assign buf_bus.we        = tx_wr;
    assign buf_bus.wdata     = bit_rev(bus_data_in);

    assign cfg.bit_out    = bit_out_q;
    assign cfg.wait_cnt   = wait_cnt_q;
    assign cfg.repeat_cnt = CNT_W'(repeat_q);
    assign cfg.ext_en     = ext_en_q;
    assign cfg.start      = start_q;
    assign cfg.soft_rst   = soft_rst_q;

endmodule

//--- rtl/spi_bit_buf.sv
`timescale 1ns/1ps

module spi_bit_buf import spi_seq_pkg::*; #(
    parameter int MEM_BYTES = 16
) (
    input  logic       SPI_CLK,
    spi_buf_bus_if.mem buf_bus,
    spi_stream_if.mem  stream
);

    localparam int BIT_AW = $clog2(8 * MEM_BYTES);
    localparam int BUF_AW = $clog2(2 * MEM_BYTES);

    logic [8*MEM_BYTES-1:0] tx_mem;
    logic [8*MEM_BYTES-1:0] rx_mem;
    logic [CNT_W-1:0]       addr_q;
    logic [BUF_AW-1:0]      rx_idx;
    logic                   is_rx;

    assign is_rx  = buf_bus.byte_addr >= BUF_AW'(MEM_BYTES);
    assign rx_idx = buf_bus.byte_addr - BUF_AW'(MEM_BYTES);

    always_ff @(posedge SPI_CLK) begin
        if (buf_bus.we && !is_rx) begin
            tx_mem[8*buf_bus.byte_addr +: 8] <= buf_bus.wdata;
        end
        if (is_rx) begin
            buf_bus.rdata <= rx_mem[8*rx_idx +: 8];
        end else begin
            buf_bus.rdata <= tx_mem[8*buf_bus.byte_addr +: 8];
        end
    end

    // the registered bit address serves both the read and the receive write.
    always_ff @(posedge SPI_CLK) begin
        addr_q <= stream.bit_addr;
        if (stream.rx_we) begin
            rx_mem[addr_q[BIT_AW-1:0]] <= stream.rx_bit;
        end
    end

    assign stream.tx_bit = tx_mem[addr_q[BIT_AW-1:0]];

endmodule

//--- rtl/spi_seq_ctrl.sv
`timescale 1ns/1ps

module spi_seq_ctrl import spi_seq_pkg::*; #(
    parameter int MEM_BYTES = 16
) (
    input  logic       SPI_CLK,
    input  logic       RST_SYNC,
    input  logic       ext_start,
    spi_cfg_if.seq     cfg,
    spi_stream_if.seq  stream
);

    localparam logic [CNT_W-1:0] MAX_BITS = CNT_W'(8 * MEM_BYTES);

    seq_state_e       state;
    logic [CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0] wait_q;
    logic [CNT_W-1:0] rep_cnt;
    logic [CNT_W-1:0] eff_bits;
    logic [2:0]       ext_ff;
    logic             ext_pulse;
    logic             start_req;
    logic             last_bit;
    logic             last_wait;
    logic             last_burst;
    logic             sen_q;
    logic             done_q;

    always_ff @(posedge SPI_CLK) begin
        if (RST_SYNC) begin
            ext_ff <= '0;
        end else begin
            ext_ff <= {ext_ff[1:0], ext_start};  // two sync stages, then the edge stage.
        end
    end

    assign ext_pulse = ext_ff[1] & ~ext_ff[2];
    assign start_req = cfg.start | (ext_pulse & cfg.ext_en);

    assign eff_bits   = (cfg.bit_out > MAX_BITS) ? MAX_BITS : cfg.bit_out;  // stay in the buffer.
    assign last_bit   = (bit_cnt + CNT_W'(1)) >= eff_bits;
    assign last_wait  = (wait_q + CNT_W'(1)) >= cfg.wait_cnt;
    assign last_burst = (cfg.repeat_cnt != '0) && ((rep_cnt + CNT_W'(1)) >= cfg.repeat_cnt);

    always_ff @(posedge SPI_CLK) begin
        if (RST_SYNC || cfg.soft_rst) begin
            state   <= SEQ_IDLE;
            bit_cnt <= '0;
            wait_q  <= '0;
            rep_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_req) begin
                state   <= SEQ_SHIFT;  // also restarts a run in progress.
                bit_cnt <= '0;
                rep_cnt <= '0;
            end else begin
                case (state)
                    SEQ_SHIFT: begin
                        if (!last_bit) begin
                            bit_cnt <= bit_cnt + CNT_W'(1);
                        end else if (cfg.wait_cnt != '0) begin
                            state  <= SEQ_WAIT;
                            wait_q <= '0;
                        end else if (last_burst) begin
                            state  <= SEQ_IDLE;
                            done_q <= 1'b1;
                        end else begin
                            bit_cnt <= '0;  // back to back bursts without a gap.
                            rep_cnt <= rep_cnt + CNT_W'(1);
                        end
                    end
                    SEQ_WAIT: begin
                        if (!last_wait) begin
                            wait_q <= wait_q + CNT_W'(1);
                        end else if (last_burst) begin
                            state  <= SEQ_IDLE;
                            done_q <= 1'b1;
                        end else begin
                            state   <= SEQ_SHIFT;
                            bit_cnt <= '0;
                            rep_cnt <= rep_cnt + CNT_W'(1);
                        end
                    end
                    default: state <= SEQ_IDLE;
                endcase
            end
        end
    end

    // sen trails the address by a cycle to match the buffer read latency.
    always_ff @(posedge SPI_CLK) begin
        if (RST_SYNC || cfg.soft_rst) begin
            sen_q <= 1'b0;
        end else begin
            sen_q <= (state == SEQ_SHIFT);
        end
    end

    assign stream.bit_addr = bit_cnt;
    assign stream.sen_int  = sen_q;
    assign stream.rx_we    = sen_q;  // one cycle behind bit_addr, as the buffer expects.
    assign cfg.done        = done_q;

endmodule

//--- rtl/spi_line_drv.sv
`timescale 1ns/1ps

module spi_line_drv (
    input  logic       SPI_CLK,
    input  logic       RST_SYNC,
    input  logic       sdo,
    spi_stream_if.line stream,
    output logic       sclk,
    output logic       sdi,
    output logic       sen,
    output logic       sld
);

    logic [1:0] sen_dly;

    // launch on the falling edge so the slave sees stable data at the sclk rise.
    always_ff @(negedge SPI_CLK) begin
        if (RST_SYNC) begin
            sdi <= 1'b0;
            sen <= 1'b0;
        end else begin
            sdi <= stream.tx_bit & stream.sen_int;
            sen <= stream.sen_int;
        end
    end

    assign sclk = SPI_CLK & sen;  // sen only moves while SPI_CLK is low.

    assign stream.rx_bit = sdo & stream.sen_int;  // written into the buffer on the rising edge.

    always_ff @(posedge SPI_CLK) begin
        if (RST_SYNC) begin
            sen_dly <= '0;
            sld     <= 1'b0;
        end else begin
            sen_dly <= {sen_dly[0], stream.sen_int};
            sld     <= sen_dly[1] & ~sen_dly[0];
        end
    end

endmodule

//--- rtl/spi_top.sv
`timescale 1ns/1ps

module spi_top #(
    parameter int MEM_BYTES = 16,
    parameter int ADDR_W    = 16
) (
    input  logic              SPI_CLK,
    input  logic              RST_SYNC,
    input  logic [ADDR_W-1:0] bus_add,
    input  logic [7:0]        bus_data_in,
    output logic [7:0]        bus_data_out,
    input  logic              bus_wr,
    input  logic              bus_rd,
    input  logic              ext_start,
    input  logic              sdo,
    output logic              sclk,
    output logic              sdi,
    output logic              sen,
    output logic              sld
);

    spi_cfg_if                               cfg_if ();
    spi_buf_bus_if #(.MEM_BYTES(MEM_BYTES))  buf_if ();
    spi_stream_if                            stream_if ();

    spi_bus_regs #(
        .MEM_BYTES (MEM_BYTES),
        .ADDR_W    (ADDR_W)
    ) u_bus_regs (
        .SPI_CLK      (SPI_CLK),
        .RST_SYNC     (RST_SYNC),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .cfg          (cfg_if),
        .buf_bus      (buf_if)
    );

    spi_bit_buf #(
        .MEM_BYTES (MEM_BYTES)
    ) u_bit_buf (
        .SPI_CLK (SPI_CLK),
        .buf_bus (buf_if),
        .stream  (stream_if)
    );

    spi_seq_ctrl #(
        .MEM_BYTES (MEM_BYTES)
    ) u_seq_ctrl (
        .SPI_CLK   (SPI_CLK),
        .RST_SYNC  (RST_SYNC),
        .ext_start (ext_start),
        .cfg       (cfg_if),
        .stream    (stream_if)
    );

    spi_line_drv u_line_drv (
        .SPI_CLK  (SPI_CLK),
        .RST_SYNC (RST_SYNC),
        .sdo      (sdo),
        .stream   (stream_if),
        .sclk     (sclk),
        .sdi      (sdi),
        .sen      (sen),
        .sld      (sld)
    );

endmodule

//--- bench/spi_tb_tests.svh
task automatic wait_sen_bursts(input int target, input int limit);
    int i;
    i = 0;
    while (sen_bursts < target && i < limit) begin
        @(negedge SPI_CLK);
        i++;
    end
    if (sen_bursts < target) begin
        fail_stop("sen bursts did not appear in time");
    end
endtask

task automatic wait_sld_pulses(input int target, input int limit);
    int i;
    i = 0;
    while (sld_pulses < target && i < limit) begin
        @(negedge SPI_CLK);
        i++;
    end
    if (sld_pulses < target) begin
        fail_stop("no sld pulse came after the burst");
    end
endtask

task automatic wait_done(input int max_polls);
    logic [7:0] st;
    st = '0;
    for (int i = 0; i < max_polls && !st[0]; i++) begin
        bus_read(ADDR_W'(REG_STATUS), st);
    end
    if (!st[0]) begin
        fail_stop("status done did not come back after the run");
    end
    repeat (4) @(negedge SPI_CLK);  // sld trails the end of sen by a few cycles.
endtask

task automatic setup_run(input int nbits, input int gap, input int reps, input logic ext_en);
    write_reg(REG_BITS_LO, nbits[7:0]);
    write_reg(REG_BITS_HI, nbits[15:8]);
    write_reg(REG_WAIT_LO, gap[7:0]);
    write_reg(REG_WAIT_HI, gap[15:8]);
    write_reg(REG_REPEAT, reps[7:0]);
    write_reg(REG_CONF, {7'b0, ext_en});
endtask

task automatic ext_pulse();
    ext_start = 1'b1;
    repeat (3) @(negedge SPI_CLK);
    ext_start = 1'b0;
endtask

// checks one finished burst of NBITS bits against the transmit model.
task automatic check_burst(input int rise0, input int sen0, input int sld0);
    logic [7:0] rx;
    check_value("sclk rises", sclk_rises - rise0, NBITS);
    check_value("sen bursts", sen_bursts - sen0, 1);
    check_value("sld pulses", sld_pulses - sld0, 1);
    for (int k = 0; k < NBITS; k++) begin
        check_value($sformatf("sdi bit %0d", k), 32'(sdi_hist[rise0 + k]),
                    32'(tx_model[k / 8][7 - k % 8]));
    end
    for (int b = 0; b < (NBITS + 7) / 8; b++) begin
        bus_read(ADDR_W'(REG_SPACE + MEM_BYTES + b), rx);
        for (int j = 0; j < 8 && 8 * b + j < NBITS; j++) begin
            check_value($sformatf("rx_buf[%0d] bit %0d", b, 7 - j), 32'(rx[7 - j]),
                        32'(tx_model[b][7 - j]));
        end
    end
    read_check(ADDR_W'(REG_STATUS), 8'h01, "status");
endtask

task automatic test_after_reset();
    logic [7:0] vals [9];
    read_check(ADDR_W'(REG_STATUS), 8'h01, "status");
    for (int i = 3; i <= 8; i++) begin
        vals[i] = rand_byte();
        bus_write(ADDR_W'(i), vals[i]);
    end
    for (int i = 3; i <= 8; i++) begin
        read_check(ADDR_W'(i), (i == 8) ? {7'b0, vals[i][0]} : vals[i], $sformatf("reg[%0d]", i));
    end
    @(posedge SPI_CLK);
    check_value("sen", 32'(sen), 0);
    @(negedge SPI_CLK);
    check_value("sclk rises", sclk_rises, 0);
    check_value("sen bursts", sen_bursts, 0);
    check_value("sld pulses", sld_pulses, 0);
endtask

task automatic test_tx_buffer();
    for (int b = 0; b < MEM_BYTES; b++) begin
        tx_model[b] = rand_byte();
        bus_write(ADDR_W'(REG_SPACE + b), tx_model[b]);
    end
    for (int b = 0; b < MEM_BYTES; b++) begin
        read_check(ADDR_W'(REG_SPACE + b), tx_model[b], $sformatf("tx_buf[%0d]", b));
    end
endtask

task automatic test_single_burst();
    int rise0;
    int sen0;
    int sld0;
    setup_run(NBITS, 0, 1, 1'b0);
    rise0 = sclk_rises;
    sen0  = sen_bursts;
    sld0  = sld_pulses;
    write_reg(REG_START, 8'h01);
    wait_sen_bursts(sen0 + 1, 10);
    wait_done(BURST_CYC);
    check_burst(rise0, sen0, sld0);
endtask

task automatic test_repeats();
    int rise0;
    int sen0;
    int sld0;
    setup_run(NBITS, GAP, 3, 1'b0);
    rise0 = sclk_rises;
    sen0  = sen_bursts;
    sld0  = sld_pulses;
    write_reg(REG_START, 8'h01);
    wait_sen_bursts(sen0 + 1, 10);
    wait_done(3 * (BURST_CYC + GAP));
    check_value("sclk rises", sclk_rises - rise0, 3 * NBITS);
    check_value("sen bursts", sen_bursts - sen0, 3);
    check_value("sld pulses", sld_pulses - sld0, 3);
    read_check(ADDR_W'(REG_STATUS), 8'h01, "status");
endtask

task automatic test_ext_start();
    int rise0;
    int sen0;
    int sld0;
    setup_run(NBITS, 0, 1, 1'b0);
    rise0 = sclk_rises;
    ext_pulse();
    for (int i = 0; i < WINDOW / 2; i++) begin
        read_check(ADDR_W'(REG_STATUS), 8'h01, "status");
    end
    check_value("sclk rises", sclk_rises - rise0, 0);
    // inverted data so every receive bit has to be written again.
    for (int b = 0; b < MEM_BYTES; b++) begin
        tx_model[b] = ~tx_model[b];
        bus_write(ADDR_W'(REG_SPACE + b), tx_model[b]);
    end
    write_reg(REG_CONF, 8'h01);
    rise0 = sclk_rises;
    sen0  = sen_bursts;
    sld0  = sld_pulses;
    ext_pulse();
    wait_sen_bursts(sen0 + 1, 20);
    wait_sld_pulses(sld0 + 1, BURST_CYC);
    check_burst(rise0, sen0, sld0);
endtask

task automatic test_soft_reset();
    int rise0;
    int sen0;
    setup_run(NBITS, 3, 0, 1'b0);
    sen0 = sen_bursts;
    write_reg(REG_START, 8'h01);
    wait_sen_bursts(sen0 + 3, 4 * BURST_CYC);
    write_reg(REG_RESET, 8'h01);
    repeat (3) @(negedge SPI_CLK);
    rise0 = sclk_rises;
    sen0  = sen_bursts;
    for (int i = 0; i < WINDOW; i++) begin
        @(posedge SPI_CLK);
        check_value("sen", 32'(sen), 0);
    end
    @(negedge SPI_CLK);
    check_value("sclk rises", sclk_rises - rise0, 0);
    check_value("sen bursts", sen_bursts - sen0, 0);
    read_check(ADDR_W'(REG_STATUS), 8'h01, "status");
endtask

//--- bench/spi_tb.sv
`timescale 1ns/1ps

module spi_tb import spi_reg_pkg::*; ();

    localparam int MEM_BYTES   = 16;
    localparam int ADDR_W      = 16;
    localparam int NBITS       = 45;  // deliberately not a whole number of bytes.
    localparam int GAP         = 5;
    localparam int WINDOW      = 40;
    localparam int BURST_CYC   = NBITS + 16;
    localparam int TEST_CYC    = 10 + 40 + 4 * MEM_BYTES + 2 * BURST_CYC
                                 + 3 * (BURST_CYC + GAP) + 2 * WINDOW + MEM_BYTES
                                 + 2 * BURST_CYC + 4 * BURST_CYC;
    localparam int CYCLE_LIMIT = 2 * TEST_CYC;

    logic              SPI_CLK;
    logic              RST_SYNC;
    logic [ADDR_W-1:0] bus_add;
    logic [7:0]        bus_data_in;
    logic [7:0]        bus_data_out;
    logic              bus_wr;
    logic              bus_rd;
    logic              ext_start;
    logic              sdo;
    logic              sclk;
    logic              sdi;
    logic              sen;
    logic              sld;
    logic [31:0]       lfsr = 32'hdccf;
    logic [7:0]        tx_model [MEM_BYTES];
    logic              sdi_hist [$];
    int                sclk_rises;
    int                sen_bursts;
    int                sld_pulses;
    int                cycle_cnt;

    assign sdo = sdi;  // the slave simply echoes the data line.

    spi_top #(
        .MEM_BYTES (MEM_BYTES),
        .ADDR_W    (ADDR_W)
    ) dut (
        .SPI_CLK      (SPI_CLK),
        .RST_SYNC     (RST_SYNC),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .ext_start    (ext_start),
        .sdo          (sdo),
        .sclk         (sclk),
        .sdi          (sdi),
        .sen          (sen),
        .sld          (sld)
    );

    initial begin
        SPI_CLK = 1'b0;
        forever #2 SPI_CLK = ~SPI_CLK;
    end

    always @(posedge sclk) begin
        if (!RST_SYNC) begin
            sdi_hist.push_back(sdi);  // sdi only moves on the falling edge.
            sclk_rises <= sclk_rises + 1;
        end
    end

    always @(posedge sen) begin
        if (!RST_SYNC) begin
            sen_bursts <= sen_bursts + 1;
        end
    end

    always @(negedge SPI_CLK) begin
        if (!RST_SYNC && sld) begin
            sld_pulses <= sld_pulses + 1;  // counts high cycles, so a wide pulse shows up.
        end
    end

    always @(posedge SPI_CLK) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            fail_stop("the run did not finish within its cycle limit");
        end
    end

    function automatic logic [7:0] rand_byte();
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            r    = {r[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic fail_stop(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge SPI_CLK);
        bus_wr = 1'b0;
    endtask

    // read data is valid in the cycle after bus_rd.
    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [7:0] data);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge SPI_CLK);
        bus_rd = 1'b0;
        data   = bus_data_out;
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [7:0] exp,
                              input string name);
        logic [7:0] got;
        bus_read(addr, got);
        check_value(name, 32'(got), 32'(exp));
    endtask

    task automatic write_reg(input reg_addr_e r, input logic [7:0] data);
        bus_write(ADDR_W'(r), data);
    endtask

    `include "spi_tb_tests.svh"

    initial begin
        RST_SYNC    = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        ext_start   = 1'b0;
        repeat (10) @(posedge SPI_CLK);
        @(negedge SPI_CLK);
        RST_SYNC = 1'b0;
        @(negedge SPI_CLK);
        test_after_reset();
        test_tx_buffer();
        test_single_burst();
        test_repeats();
        test_ext_start();
        test_soft_reset();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- src.f
+incdir+bench
rtl/spi_reg_pkg.sv
rtl/spi_seq_pkg.sv
rtl/spi_ifs.sv
rtl/spi_bus_regs.sv
rtl/spi_bit_buf.sv
rtl/spi_seq_ctrl.sv
rtl/spi_line_drv.sv
rtl/spi_top.sv
bench/spi_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = spi_tb
FILELIST = src.f
BUILD    = obj_dir
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the run passes only when the pass message shows up in the output.
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
